/* compile.f */
+incdir+src
src/alu_pkg.sv
src/alu_decoder.sv
src/alu_core.sv
src/alu_apb_regs.sv
src/alu_unit_top.sv
+incdir+testbench
testbench/tb_alu_unit.sv

/* run.sh */
#!/bin/sh
# builds the ALU peripheral testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_alu_unit -o sim_alu \
	&& ./obj_dir/sim_alu > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0

/* src/alu_apb_regs.sv */
// APB register block holding operands, instruction, captured result and status
`timescale 1ns/10ps
`default_nettype none

`include "alu_macros.svh"

module alu_apb_regs (
	input  logic               clk,
	input  logic               rst_n,
	input  alu_pkg::apb_req_t  apb_req,
	output alu_pkg::apb_rsp_t  apb_rsp,
	output alu_pkg::xlen_t     src1,
	output alu_pkg::xlen_t     src2,
	output alu_pkg::inst_t     inst,
	input  alu_pkg::xlen_t     result,
	input  logic               illegal
);
	import alu_pkg::*;

	apb_data_t src1_lo, src1_hi;
	apb_data_t src2_lo, src2_hi;
	inst_t     inst_q;
	xlen_t     result_q;
	logic      illegal_q;
	logic      done;
	logic      pending;   // high the cycle after an INST write

	logic      access;
	logic      wr_en;
	logic      rd_en;
	logic      inst_wr;
	logic      mapped;
	logic      read_only;
	apb_data_t rdata;

	assign access  = apb_req.psel & apb_req.penable;
	assign wr_en   = access & apb_req.pwrite;
	assign rd_en   = access & ~apb_req.pwrite;
	assign inst_wr = wr_en & (apb_req.paddr == `ALU_REG_INST);

	// offset decode for reads and error response
	always_comb begin
		mapped    = 1'b1;
		read_only = 1'b0;
		rdata     = '0;
		case (apb_req.paddr)
			`ALU_REG_SRC1_LO: rdata = src1_lo;
			`ALU_REG_SRC1_HI: rdata = src1_hi;
			`ALU_REG_SRC2_LO: rdata = src2_lo;
			`ALU_REG_SRC2_HI: rdata = src2_hi;
			`ALU_REG_INST:    rdata = inst_q;
			`ALU_REG_RES_LO: begin
				rdata     = result_q[31:0];
				read_only = 1'b1;
			end
			`ALU_REG_RES_HI: begin
				rdata     = result_q[63:32];
				read_only = 1'b1;
			end
			`ALU_REG_STATUS: begin
				rdata     = {30'b0, illegal_q, done};
				read_only = 1'b1;
			end
			default: mapped = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			src1_lo   <= '0;
			src1_hi   <= '0;
			src2_lo   <= '0;
			src2_hi   <= '0;
			inst_q    <= '0;
			result_q  <= '0;
			illegal_q <= 1'b0;
			done      <= 1'b0;
			pending   <= 1'b0;
		end else begin
			if (wr_en) begin
				case (apb_req.paddr)
					`ALU_REG_SRC1_LO: src1_lo <= apb_req.pwdata;
					`ALU_REG_SRC1_HI: src1_hi <= apb_req.pwdata;
					`ALU_REG_SRC2_LO: src2_lo <= apb_req.pwdata;
					`ALU_REG_SRC2_HI: src2_hi <= apb_req.pwdata;
					`ALU_REG_INST:    inst_q  <= apb_req.pwdata;
					default: ;            // read-only and unmapped writes dropped
				endcase
			end
			pending <= inst_wr;
			if (inst_wr)
				done <= 1'b0;
			else if (pending)
				done <= 1'b1;
			if (pending) begin  // ALU has settled on the new instruction
				result_q  <= result;
				illegal_q <= illegal;
			end
		end
	end

	assign src1 = {src1_hi, src1_lo};
	assign src2 = {src2_hi, src2_lo};
	assign inst = inst_q;

	assign apb_rsp = '{
		prdata:  rd_en ? rdata : '0,
		pready:  1'b1,       // no wait states
		pslverr: access & (~mapped | (apb_req.pwrite & read_only))
	};

endmodule

`default_nettype wire

/* src/alu_core.sv */
// combinational 64-bit ALU driven by a one-hot operation vector, used inside alu_unit_top
`timescale 1ns/10ps
`default_nettype none

`include "alu_macros.svh"

module alu_core (
	input  alu_pkg::alu_ctrl_t ctrl,
	input  alu_pkg::xlen_t     src1,
	input  alu_pkg::xlen_t     src2,
	input  logic               use_imm,
	input  alu_pkg::xlen_t     imm,
	output alu_pkg::xlen_t     result
);
	import alu_pkg::*;

	localparam int SHW = $clog2(`ALU_XLEN);

	logic op_add, op_sub, op_slt, op_sltu, op_and, op_or, op_xor;
	logic op_sll, op_srl, op_sra, op_lui, op_mul, op_div;

	xlen_t opb;   // second operand after immediate select
	xlen_t adder_b;
	logic  adder_cin;
	xlen_t adder_sum;
	logic  adder_cout;

	xlen_t slt_result;
	xlen_t sltu_result;
	xlen_t sll_result;
	xlen_t srl_result;
	xlen_t sra_result;
	xlen_t lui_result;
	xlen_t mul_result;
	xlen_t div_result;

	assign op_add  = ctrl[`ALU_OP_ADD];
	assign op_sub  = ctrl[`ALU_OP_SUB];
	assign op_slt  = ctrl[`ALU_OP_SLT];
	assign op_sltu = ctrl[`ALU_OP_SLTU];
	assign op_and  = ctrl[`ALU_OP_AND];
	assign op_or   = ctrl[`ALU_OP_OR];
	assign op_xor  = ctrl[`ALU_OP_XOR];
	assign op_sll  = ctrl[`ALU_OP_SLL];
	assign op_srl  = ctrl[`ALU_OP_SRL];
	assign op_sra  = ctrl[`ALU_OP_SRA];
	assign op_lui  = ctrl[`ALU_OP_LUI];
	assign op_mul  = ctrl[`ALU_OP_MUL];
	assign op_div  = ctrl[`ALU_OP_DIV];

	assign opb = use_imm ? imm : src2;

	// one adder for add, sub and both compares
	assign adder_cin = op_sub | op_slt | op_sltu;
	assign adder_b   = adder_cin ? ~opb : opb;
	assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b}
		+ {{`ALU_XLEN{1'b0}}, adder_cin};

	// less when only src1 is negative or when equal signs give a negative difference
	assign slt_result = {{(`ALU_XLEN-1){1'b0}},
		(src1[`ALU_XLEN-1] & ~opb[`ALU_XLEN-1])
		| (~(src1[`ALU_XLEN-1] ^ opb[`ALU_XLEN-1]) & adder_sum[`ALU_XLEN-1])};

	assign sltu_result = {{(`ALU_XLEN-1){1'b0}}, ~adder_cout}; // borrow out

	assign sll_result = src1 << opb[SHW-1:0];
	assign srl_result = src1 >> opb[SHW-1:0];
	assign sra_result = $signed(src1) >>> opb[SHW-1:0];

	assign lui_result = {{(`ALU_XLEN-32){opb[19]}}, opb[19:0], 12'b0};

	assign mul_result = src1 * opb;   // low half only
	assign div_result = (opb == '0) ? '1 : src1 / opb;

	assign result = ({`ALU_XLEN{op_add | op_sub}} & adder_sum)
		| ({`ALU_XLEN{op_slt}}  & slt_result)
		| ({`ALU_XLEN{op_sltu}} & sltu_result)
		| ({`ALU_XLEN{op_and}}  & (src1 & opb))
		| ({`ALU_XLEN{op_or}}   & (src1 | opb))
		| ({`ALU_XLEN{op_xor}}  & (src1 ^ opb))
		| ({`ALU_XLEN{op_sll}}  & sll_result)
		| ({`ALU_XLEN{op_srl}}  & srl_result)
		| ({`ALU_XLEN{op_sra}}  & sra_result)
		| ({`ALU_XLEN{op_lui}}  & lui_result)
		| ({`ALU_XLEN{op_mul}}  & mul_result)
		| ({`ALU_XLEN{op_div}}  & div_result);

endmodule

`default_nettype wire

/* src/alu_decoder.sv */
// combinational RV64 decoder for OP, OP-IMM, LUI, mul and divu, feeds alu_core
`timescale 1ns/10ps
`default_nettype none

`include "alu_macros.svh"

module alu_decoder (
	input  alu_pkg::inst_t   inst,
	output alu_pkg::alu_dec_t dec,
	output logic             illegal
);
	import alu_pkg::*;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] funct6;   // OP-IMM shifts carry a 6-bit shamt
	alu_ctrl_t  ctrl;
	logic       use_imm;
	xlen_t      imm;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign funct6 = inst[31:26];

	always_comb begin
		ctrl    = '0;
		use_imm = 1'b0;
		imm     = '0;
		case (opcode)
			OPC_OP: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: ctrl[`ALU_OP_ADD]  = 1'b1;
						3'b001: ctrl[`ALU_OP_SLL]  = 1'b1;
						3'b010: ctrl[`ALU_OP_SLT]  = 1'b1;
						3'b011: ctrl[`ALU_OP_SLTU] = 1'b1;
						3'b100: ctrl[`ALU_OP_XOR]  = 1'b1;
						3'b101: ctrl[`ALU_OP_SRL]  = 1'b1;
						3'b110: ctrl[`ALU_OP_OR]   = 1'b1;
						default: ctrl[`ALU_OP_AND] = 1'b1;
					endcase
				end else if (funct7 == 7'b0100000) begin
					if (funct3 == 3'b000)
						ctrl[`ALU_OP_SUB] = 1'b1;
					else if (funct3 == 3'b101)
						ctrl[`ALU_OP_SRA] = 1'b1;
				end else if (funct7 == 7'b0000001) begin // M extension subset
					if (funct3 == 3'b000)
						ctrl[`ALU_OP_MUL] = 1'b1;
					else if (funct3 == 3'b101)
						ctrl[`ALU_OP_DIV] = 1'b1;
				end
			end
			OPC_OP_IMM: begin
				use_imm = 1'b1;
				imm     = {{(`ALU_XLEN-12){inst[31]}}, inst[31:20]};
				case (funct3)
					3'b000: ctrl[`ALU_OP_ADD]  = 1'b1;
					3'b010: ctrl[`ALU_OP_SLT]  = 1'b1;
					3'b011: ctrl[`ALU_OP_SLTU] = 1'b1;
					3'b100: ctrl[`ALU_OP_XOR]  = 1'b1;
					3'b110: ctrl[`ALU_OP_OR]   = 1'b1;
					3'b111: ctrl[`ALU_OP_AND]  = 1'b1;
					3'b001: ctrl[`ALU_OP_SLL]  = (funct6 == 6'b000000);
					default: begin            // srli or srai
						ctrl[`ALU_OP_SRL] = (funct6 == 6'b000000);
						ctrl[`ALU_OP_SRA] = (funct6 == 6'b010000);
					end
				endcase
			end
			OPC_LUI: begin
				use_imm           = 1'b1;
				imm               = {{(`ALU_XLEN-20){1'b0}}, inst[31:12]}; // core sign-extends
				ctrl[`ALU_OP_LUI] = 1'b1;
			end
			default: ;
		endcase
	end

	// nothing selected means the encoding is not supported
	assign illegal = ~|ctrl;

	assign dec = '{ctrl: ctrl, use_imm: use_imm, imm: imm};

endmodule

`default_nettype wire

/* src/alu_macros.svh */
// data width, operation count, one-hot bit positions and APB register map, include where needed
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

`define ALU_XLEN 64
`define ALU_NOPS 13

// bit positions in the one-hot operation vector
`define ALU_OP_ADD  0
`define ALU_OP_SUB  1
`define ALU_OP_SLT  2
`define ALU_OP_SLTU 3
`define ALU_OP_AND  4
`define ALU_OP_OR   5
`define ALU_OP_XOR  6
`define ALU_OP_SLL  7
`define ALU_OP_SRL  8
`define ALU_OP_SRA  9
`define ALU_OP_LUI  10
`define ALU_OP_MUL  11
`define ALU_OP_DIV  12

// byte offsets of the 32-bit registers
`define ALU_REG_SRC1_LO 8'h00
`define ALU_REG_SRC1_HI 8'h04
`define ALU_REG_SRC2_LO 8'h08
`define ALU_REG_SRC2_HI 8'h0C
`define ALU_REG_INST    8'h10
`define ALU_REG_RES_LO  8'h14
`define ALU_REG_RES_HI  8'h18
`define ALU_REG_STATUS  8'h1C

`endif

/* src/alu_pkg.sv */
// types shared by the ALU peripheral, imported by every module of the design
`default_nettype none

`include "alu_macros.svh"

package alu_pkg;

	typedef logic [`ALU_XLEN-1:0] xlen_t;     // operand or result
	typedef logic [`ALU_NOPS-1:0] alu_ctrl_t; // one-hot with add at bit 0 up to div at bit 12
	typedef logic [31:0]          inst_t;
	typedef logic [31:0]          apb_data_t;
	typedef logic [7:0]           apb_addr_t;

	// host to slave
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// slave to host
	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	// decoder output consumed by the ALU
	typedef struct packed {
		alu_ctrl_t ctrl;
		logic      use_imm; // take imm instead of src2
		xlen_t     imm;     // sign-extended immediate
	} alu_dec_t;

endpackage

`default_nettype wire

/* src/alu_unit_top.sv */
// top of the APB ALU peripheral, connects register block, decoder and ALU
`timescale 1ns/10ps
`default_nettype none

module alu_unit_top (
	input  logic              clk,
	input  logic              rst_n,
	input  alu_pkg::apb_req_t apb_req,
	output alu_pkg::apb_rsp_t apb_rsp
);
	import alu_pkg::*;

	xlen_t    src1;
	xlen_t    src2;
	inst_t    inst;
	alu_dec_t dec;
	logic     illegal;
	xlen_t    result;

	alu_apb_regs u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.src1    (src1),
		.src2    (src2),
		.inst    (inst),
		.result  (result),
		.illegal (illegal)
	);

	alu_decoder u_dec (
		.inst    (inst),
		.dec     (dec),
		.illegal (illegal)
	);

	// operand select happens in the core
	alu_core u_core (
		.ctrl    (dec.ctrl),
		.src1    (src1),
		.src2    (src2),
		.use_imm (dec.use_imm),
		.imm     (dec.imm),
		.result  (result)
	);

endmodule

`default_nettype wire

/* testbench/tb_alu_model.svh */
// reference model of the ALU peripheral, included inside the testbench module body
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// operation name of an instruction word or illegal for unsupported encodings
function automatic string decode_inst(input logic [31:0] ins);
	logic [6:0] opc;
	logic [9:0] f73;   // funct7 then funct3
	logic [5:0] f6;
	opc = ins[6:0];
	f73 = {ins[31:25], ins[14:12]};
	f6  = ins[31:26];
	decode_inst = "illegal";
	if (opc == 7'b0110011) begin
		case (f73)
			10'b0000000_000: decode_inst = "add";
			10'b0000000_001: decode_inst = "sll";
			10'b0000000_010: decode_inst = "slt";
			10'b0000000_011: decode_inst = "sltu";
			10'b0000000_100: decode_inst = "xor";
			10'b0000000_101: decode_inst = "srl";
			10'b0000000_110: decode_inst = "or";
			10'b0000000_111: decode_inst = "and";
			10'b0100000_000: decode_inst = "sub";
			10'b0100000_101: decode_inst = "sra";
			10'b0000001_000: decode_inst = "mul";
			10'b0000001_101: decode_inst = "divu";
			default: ;
		endcase
	end else if (opc == 7'b0010011) begin
		case (ins[14:12])
			3'b000: decode_inst = "addi";
			3'b010: decode_inst = "slti";
			3'b011: decode_inst = "sltiu";
			3'b100: decode_inst = "xori";
			3'b110: decode_inst = "ori";
			3'b111: decode_inst = "andi";
			3'b001: if (f6 == 6'b000000) decode_inst = "slli";
			default: begin
				if (f6 == 6'b000000)
					decode_inst = "srli";
				else if (f6 == 6'b010000)
					decode_inst = "srai";
			end
		endcase
	end else if (opc == 7'b0110111) begin
		decode_inst = "lui";
	end
endfunction

// expected {illegal, result} for operands a and b under an instruction
function automatic logic [64:0] expected_result(input logic [63:0] a, input logic [63:0] b,
	input logic [31:0] ins);
	string       op;
	logic [63:0] opb;
	logic [63:0] y;
	op  = decode_inst(ins);
	opb = (ins[6:0] == 7'b0010011) ? {{52{ins[31]}}, ins[31:20]} : b;
	case (op)
		"add", "addi":   y = a + opb;
		"sub":           y = a - opb;
		"slt", "slti":   y = {63'b0, $signed(a) < $signed(opb)};
		"sltu", "sltiu": y = {63'b0, a < opb};
		"and", "andi":   y = a & opb;
		"or", "ori":     y = a | opb;
		"xor", "xori":   y = a ^ opb;
		"sll", "slli":   y = a << opb[5:0];
		"srl", "srli":   y = a >> opb[5:0];
		"sra", "srai":   y = $signed(a) >>> opb[5:0];
		"lui":           y = {{32{ins[31]}}, ins[31:12], 12'h000};
		"mul":           y = a * opb;
		"divu":          y = (opb == '0) ? '1 : a / opb;   // zero divisor gives all ones
		default:         y = '0;
	endcase
	expected_result = {op == "illegal", y};
endfunction

`endif

/* testbench/tb_alu_unit.sv */
// self-checking testbench for the APB ALU peripheral, simulation top with dut0 inside
`timescale 1ns/10ps
`default_nettype none

`include "alu_macros.svh"

module tb_alu_unit;
	import alu_pkg::*;

	`include "tb_alu_model.svh"

	localparam int PERIOD = 40;
	localparam int N_RAND = 24;   // runs per operation kind
	localparam int N_RUNS = 22 * N_RAND + 16;
	// about ten three-cycle transfers per run with twofold margin
	localparam int WATCHDOG_NS = (N_RUNS + 20) * 10 * 3 * PERIOD * 2;

	// funct7 and funct3 of the ten base OP operations
	localparam logic [9:0] BASE_OPS [10] = '{
		10'b0000000_000, 10'b0000000_001, 10'b0000000_010, 10'b0000000_011,
		10'b0000000_100, 10'b0000000_101, 10'b0000000_110, 10'b0000000_111,
		10'b0100000_000, 10'b0100000_101
	};

	logic     clk;
	logic     rst_n;
	apb_req_t req;
	apb_rsp_t rsp;
	integer   seed;
	int       errors;
	int       checks;
	int       err_mark;   // error count when the current test began
	int       test_num;
	string    test_name;

	// handshake to the compare process
	int          chk_seq;
	int          chk_ack;
	string       chk_name;
	logic [63:0] chk_exp;
	logic [63:0] chk_act;

	alu_unit_top dut0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (req),
		.apb_rsp (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// compares each value handed over by the stimulus
	initial begin
		chk_ack = 0;
		errors  = 0;
		checks  = 0;
		forever begin
			wait (chk_seq != chk_ack);
			checks++;
			assert (chk_act === chk_exp) else begin
				errors++;
				$display("FAIL at %0t: %s expected %h, got %h", $time, chk_name, chk_exp, chk_act);
			end
			chk_ack = chk_seq;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		chk_name = name;
		chk_exp  = exp;
		chk_act  = act;
		chk_seq++;
		wait (chk_ack == chk_seq);
	endtask

	// one APB transfer driven on falling edges
	task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
		output apb_data_t rdata, output logic err);
		@(negedge clk);
		req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(negedge clk);
		req.penable = 1'b1;
		#(PERIOD / 4);   // middle of the access cycle low phase
		rdata = rsp.prdata;
		err   = rsp.pslverr;
		check("pready", 64'h1, 64'(rsp.pready));
		@(negedge clk);
		req = '0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
		apb_data_t rd;
		logic      err;
		apb_xfer(1'b1, addr, wdata, rd, err);
		check("pslverr", 64'h0, 64'(err));
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
		logic err;
		apb_xfer(1'b0, addr, '0, rdata, err);
		check("pslverr", 64'h0, 64'(err));
	endtask

	task automatic load_operands(input logic [63:0] a, input logic [63:0] b);
		apb_write(`ALU_REG_SRC1_LO, a[31:0]);
		apb_write(`ALU_REG_SRC1_HI, a[63:32]);
		apb_write(`ALU_REG_SRC2_LO, b[31:0]);
		apb_write(`ALU_REG_SRC2_HI, b[63:32]);
	endtask

	task automatic read_result(output logic [63:0] res, output apb_data_t st);
		apb_data_t lo;
		apb_data_t hi;
		apb_read(`ALU_REG_RES_LO, lo);
		apb_read(`ALU_REG_RES_HI, hi);
		apb_read(`ALU_REG_STATUS, st);
		res = {hi, lo};
	endtask

	// load operands, issue the instruction, read back and compare with the model
	task automatic run_inst(input logic [63:0] a, input logic [63:0] b, input inst_t ins);
		logic [64:0] exp;
		logic [63:0] res;
		apb_data_t   st;
		exp = expected_result(a, b, ins);
		load_operands(a, b);
		apb_write(`ALU_REG_INST, ins);
		read_result(res, st);
		check({decode_inst(ins), " result"}, exp[63:0], res);
		check({decode_inst(ins), " status"}, {62'b0, exp[64], 1'b1}, 64'(st));
	endtask

	function automatic logic [63:0] rand_word();
		rand_word = {$random(seed), $random(seed)};
	endfunction

	// random values mixed with sign boundaries
	function automatic logic [63:0] rand_operand();
		int unsigned pick;
		pick = $unsigned($random(seed)) % 8;
		case (pick)
			0: rand_operand = 64'h8000_0000_0000_0000;
			1: rand_operand = 64'h7fff_ffff_ffff_ffff;
			2: rand_operand = '1;
			3: rand_operand = '0;
			default: rand_operand = rand_word();
		endcase
	endfunction

	// random register fields that the DUT ignores
	function automatic inst_t r_inst(input logic [6:0] f7, input logic [2:0] f3);
		r_inst = {f7, 5'($random(seed)), 5'($random(seed)), f3,
			5'($random(seed)), 7'b0110011};
	endfunction

	function automatic inst_t i_inst(input logic [11:0] imm, input logic [2:0] f3);
		i_inst = {imm, 5'($random(seed)), f3, 5'($random(seed)), 7'b0010011};
	endfunction

	function automatic inst_t u_inst(input logic [19:0] field);
		u_inst = {field, 5'($random(seed)), 7'b0110111};
	endfunction

	// OP-IMM word of kind 0 to 8 with shift amounts 0 and 63 on the first two runs
	function automatic inst_t imm_inst(input int kind, input int run);
		logic [11:0] imm;
		logic [5:0]  sh;
		imm = 12'($random(seed));
		sh  = (run == 0) ? 6'd0 : (run == 1) ? 6'd63 : 6'($random(seed));
		case (kind)
			0: imm_inst = i_inst(imm, 3'b000);
			1: imm_inst = i_inst(imm, 3'b010);
			2: imm_inst = i_inst(imm, 3'b011);
			3: imm_inst = i_inst(imm, 3'b100);
			4: imm_inst = i_inst(imm, 3'b110);
			5: imm_inst = i_inst(imm, 3'b111);
			6: imm_inst = i_inst({6'b000000, sh}, 3'b001);
			7: imm_inst = i_inst({6'b000000, sh}, 3'b101);
			default: imm_inst = i_inst({6'b010000, sh}, 3'b101);
		endcase
	endfunction

	task automatic begin_test(input string name);
		test_num++;
		test_name = name;
		err_mark  = errors;
	endtask

	task automatic end_test();
		if (errors == err_mark)
			$display("test %0d %s: pass", test_num, test_name);
		else
			$display("test %0d %s: fail, %0d errors", test_num, test_name, errors - err_mark);
	endtask

	initial begin
		int          i;
		int          k;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] res;
		apb_data_t   st;
		apb_data_t   rd;
		logic        err;
		rst_n    = 1'b0;
		req      = '0;
		seed     = 32'h9c2c;
		chk_seq  = 0;
		test_num = 0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		begin_test("reset values and pslverr");
		read_result(res, st);
		check("result", 64'h0, res);
		check("status", 64'h0, 64'(st));
		apb_xfer(1'b0, 8'h20, '0, rd, err);
		check("pslverr unmapped read", 64'h1, 64'(err));
		apb_xfer(1'b1, 8'h24, 32'h0000_1234, rd, err);
		check("pslverr unmapped write", 64'h1, 64'(err));
		apb_xfer(1'b1, `ALU_REG_RES_LO, 32'h0000_dead, rd, err);
		check("pslverr RES_LO write", 64'h1, 64'(err));
		end_test();

		begin_test("register ops");
		for (k = 0; k < 10; k++)
			for (i = 0; i < N_RAND; i++) begin
				a = rand_operand();
				b = (i % 4 == 0) ? a : rand_operand();   // equal operands now and then
				run_inst(a, b, r_inst(BASE_OPS[k][9:3], BASE_OPS[k][2:0]));
			end
		run_inst(64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, r_inst(7'b0, 3'b010));
		run_inst(64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000, r_inst(7'b0, 3'b011));
		end_test();

		begin_test("immediate ops and lui");
		for (k = 0; k < 9; k++)
			for (i = 0; i < N_RAND; i++)
				run_inst(rand_operand(), rand_word(), imm_inst(k, i));
		for (i = 0; i < N_RAND; i++)
			run_inst(rand_operand(), rand_word(), u_inst(20'($random(seed))));
		run_inst(rand_word(), rand_word(), u_inst(20'h80000));   // sign extension of lui
		end_test();

		begin_test("mul and divu");
		for (i = 0; i < N_RAND; i++) begin
			a = rand_word();
			b = (i % 3 == 0) ? {32'h0, $random(seed)} : rand_operand();
			run_inst(a, b, r_inst(7'b0000001, 3'b000));
			run_inst(a, b, r_inst(7'b0000001, 3'b101));
		end
		run_inst(rand_word(), 64'h0, r_inst(7'b0000001, 3'b101));
		run_inst(64'hffff_ffff_ffff_fff0, 64'h3, r_inst(7'b0000001, 3'b101));
		end_test();

		begin_test("illegal instructions");
		run_inst(rand_word(), rand_word(), 32'hffff_ffff);
		run_inst(rand_word(), rand_word(), {25'($random(seed)), 7'b0000011});   // load
		run_inst(rand_word(), rand_word(), r_inst(7'b0100000, 3'b001));
		run_inst(rand_word(), rand_word(), r_inst(7'b0000001, 3'b100));   // signed div
		run_inst(rand_word(), rand_word(), i_inst({6'b010000, 6'd3}, 3'b001));
		run_inst(rand_word(), rand_word(), r_inst(7'b0, 3'b000));   // legal add clears illegal
		end_test();

		begin_test("operand rewrite after capture");
		a = rand_word();
		b = rand_word();
		run_inst(a, b, r_inst(7'b0, 3'b100));
		load_operands(~a, rand_word());
		read_result(res, st);
		check("result after rewrite", a ^ b, res);
		check("status after rewrite", 64'h1, 64'(st));
		end_test();

		$display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
